//--- design/cpuArchPkg.sv
package cpuArchPkg;

    localparam int wordWidth   = 32;
    localparam int opcodeWidth = 6;
    localparam int regIdxWidth = 5;
    localparam int causeWidth  = 5;
    localparam int immWidth    = 16;
    localparam int numRegs     = 32;
    localparam int vectorWidth = 4;

    // instruction field positions, low bit of each field
    localparam int opcodeLsb = 26;
    localparam int rdLsb     = 21;
    localparam int raLsb     = 16;
    localparam int rbLsb     = 11;
    localparam int immLsb    = 0;

    typedef logic [wordWidth-1:0]   wordT;
    typedef logic [regIdxWidth-1:0] regIdxT;
    typedef logic [causeWidth-1:0]  causeT;

    typedef enum logic [opcodeWidth-1:0] {
        opAdd     = 6'h00,
        opSub     = 6'h01,
        opAnd     = 6'h02,
        opOr      = 6'h03,
        opXor     = 6'h04,
        opShl     = 6'h05,
        opShr     = 6'h06,
        opAddi    = 6'h08,
        opLdw     = 6'h10,
        opStw     = 6'h11,
        opBz      = 6'h18,
        opBrk     = 6'h20,
        opRdcause = 6'h21,
        opEret    = 6'h22
    } opcodeT;

    localparam causeT causeOverflow  = 5'd1;
    localparam causeT causeBreak     = 5'd2;
    localparam causeT causeUnknown   = 5'd4;
    localparam causeT causeInterrupt = 5'h10;  // vector goes in the low 4 bits

    localparam wordT instrBytes   = 32'd4;
    localparam wordT isrAddress   = 32'h0000_0100;
    localparam wordT resetAddress = 32'h0000_0000;

endpackage

//--- design/cpuCtrlPkg.sv
package cpuCtrlPkg;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback,
        stTrap
    } ctrlStateT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluShl,
        aluShr
    } aluOpT;

    typedef enum logic [1:0] {
        wbAlu,
        wbLoad,
        wbCause
    } wbSelT;

    typedef enum logic [1:0] {
        busIdle,
        busFetch,
        busLoad,
        busStore
    } busKindT;

    localparam logic [3:0] bweWord = 4'hF;  // word accesses only

endpackage

//--- design/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import cpuArchPkg::*, cpuCtrlPkg::*; (
    input  aluOpT aluOp,
    input  wordT  operandA,
    input  wordT  operandB,
    output wordT  aluResult,
    output logic  aluOverflow
);

    wordT       sum;
    wordT       diff;
    logic [4:0] shamt;
    logic       addOverflow;
    logic       subOverflow;

    assign sum   = operandA + operandB;
    assign diff  = operandA - operandB;
    assign shamt = operandB[4:0];

    // operands of equal sign giving a result of the other sign
    assign addOverflow = (operandA[wordWidth-1] == operandB[wordWidth-1]) &&
                         (sum[wordWidth-1] != operandA[wordWidth-1]);
    // operands of different sign, result sign differs from A
    assign subOverflow = (operandA[wordWidth-1] != operandB[wordWidth-1]) &&
                         (diff[wordWidth-1] != operandA[wordWidth-1]);

    always_comb begin
        aluResult   = sum;
        aluOverflow = 1'b0;
        case (aluOp)
            aluAdd: begin
                aluResult   = sum;
                aluOverflow = addOverflow;
            end
            aluSub: begin
                aluResult   = diff;
                aluOverflow = subOverflow;
            end
            aluAnd:  aluResult = operandA & operandB;
            aluOr:   aluResult = operandA | operandB;
            aluXor:  aluResult = operandA ^ operandB;
            aluShl:  aluResult = operandA << shamt;
            aluShr:  aluResult = operandA >> shamt;   // logical
            default: aluResult = sum;
        endcase
    end

endmodule

//--- design/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuArchPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT raIdx,
    input  regIdxT rbIdx,
    input  regIdxT rdIdx,
    input  logic   regWrite,
    input  wordT   regWriteData,
    output wordT   raValue,
    output wordT   rbValue,
    output wordT   rdValue
);

    wordT regs [numRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rdIdx != '0) begin
            regs[rdIdx] <= regWriteData;     // r0 stays zero
        end
    end

    assign raValue = regs[raIdx];
    assign rbValue = regs[rbIdx];
    assign rdValue = regs[rdIdx];   // store data for STW

    // r0 reads as zero on the operand and store ports
    assert property (@(posedge clk) disable iff (!rstN) raIdx == '0 |-> raValue == '0);
    assert property (@(posedge clk) disable iff (!rstN) rdIdx == '0 |-> rdValue == '0);

endmodule

//--- design/exceptionUnit.sv
`timescale 1ns/1ps

module exceptionUnit import cpuArchPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  wordT                   pc,
    input  logic                   overflowTrap,
    input  logic                   breakTrap,
    input  logic                   unknownTrap,
    input  logic                   eret,
    input  logic                   fetchBoundary,
    input  logic                   interruptRequest,
    input  logic [vectorWidth-1:0] interruptIn,
    output logic                   trapTaken,
    output logic                   interruptAcknowledge,
    output logic [vectorWidth-1:0] interruptOut,
    output causeT                  cause,
    output wordT                   epc
);

    logic                   intEnable;
    logic                   syncTrap;
    logic                   irqTake;
    logic [vectorWidth-1:0] heldVector;
    causeT                  trapCause;

    assign syncTrap  = overflowTrap || breakTrap || unknownTrap;
    assign irqTake   = fetchBoundary && interruptRequest && intEnable && !syncTrap;
    assign trapTaken = syncTrap || irqTake;

    assign interruptAcknowledge = irqTake;
    assign interruptOut         = irqTake ? interruptIn : heldVector;

    always_comb begin
        if (overflowTrap)
            trapCause = causeOverflow;
        else if (breakTrap)
            trapCause = causeBreak;
        else if (unknownTrap)
            trapCause = causeUnknown;
        else
            trapCause = causeInterrupt | causeT'(interruptIn);
    end

    always_ff @(posedge clk) begin
        if (trapTaken) begin
            cause <= trapCause;
            epc   <= irqTake ? pc : pc + instrBytes;  // irq resumes the unfetched instr
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            intEnable  <= 1'b1;
            heldVector <= '0;
        end else if (trapTaken) begin
            intEnable <= 1'b0;   // masked until ERET
            if (irqTake) begin
                heldVector <= interruptIn;
            end
        end else if (eret) begin
            intEnable  <= 1'b1;
            heldVector <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({overflowTrap, breakTrap, unknownTrap}));

endmodule

//--- design/busUnit.sv
`timescale 1ns/1ps

module busUnit import cpuArchPkg::*, cpuCtrlPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       busStart,
    input  busKindT    busKind,
    input  wordT       busAddress,
    input  wordT       busWriteData,
    input  logic       waitRequest,
    input  logic       readValid,
    input  wordT       dataIn,
    output logic       read,
    output logic       write,
    output logic [3:0] bwe,
    output wordT       address,
    output wordT       dataOut,
    output logic       busDone,
    output wordT       busReadData
);

    typedef enum logic [1:0] {phIdle, phRequest, phWaitData, phDone} busPhaseT;

    busPhaseT phase;

    assign busDone = (phase == phDone);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= phIdle;
            read  <= 1'b0;
            write <= 1'b0;
            bwe   <= '0;
        end else begin
            case (phase)
                phIdle: begin
                    if (busStart) begin
                        read  <= (busKind == busFetch) || (busKind == busLoad);
                        write <= (busKind == busStore);
                        bwe   <= (busKind == busStore) ? bweWord : '0;
                        phase <= phRequest;
                    end
                end
                phRequest: begin
                    if (!waitRequest) begin   // accepted this cycle
                        read  <= 1'b0;
                        write <= 1'b0;
                        bwe   <= '0;
                        phase <= write ? phDone : phWaitData;
                    end
                end
                phWaitData: begin
                    if (readValid) begin
                        phase <= phDone;
                    end
                end
                default: phase <= phIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == phIdle && busStart) begin
            address <= busAddress;
            dataOut <= busWriteData;
        end
        if (phase == phWaitData && readValid) begin
            busReadData <= dataIn;
        end
    end

    // controller waits for busDone before the next request
    assert property (@(posedge clk) disable iff (!rstN) busStart |-> phase == phIdle);
    assert property (@(posedge clk) disable iff (!rstN) !(read && write));

endmodule

//--- design/cpuController.sv
`timescale 1ns/1ps

module cpuController import cpuArchPkg::*, cpuCtrlPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  wordT    instruction,
    input  logic    busDone,
    input  logic    trapTaken,
    input  wordT    busReadData,
    input  wordT    aluResult,
    input  wordT    rdValue,
    input  wordT    raValue,
    input  wordT    epc,
    input  logic    aluOverflow,
    output logic    busStart,
    output logic    regWrite,
    output logic    fetchBoundary,
    output logic    overflowTrap,
    output logic    breakTrap,
    output logic    unknownTrap,
    output logic    eret,
    output busKindT busKind,
    output wordT    busAddress,
    output wordT    busWriteData,
    output wordT    pc,
    output wordT    regWriteData,
    output aluOpT   aluOp,
    output wbSelT   wbSel,
    output regIdxT  rdIdx,
    output regIdxT  raIdx,
    output regIdxT  rbIdx,
    output logic    useImm,
    output wordT    immediate
);

    ctrlStateT state;
    wordT      instrReg;
    opcodeT    opcode;
    logic      busBusy;       // a bus transaction is outstanding
    logic      known;
    logic      writesReg;
    logic      isMem;
    logic      checkOverflow;
    logic      branchTaken;
    wordT      branchTarget;

    assign opcode    = opcodeT'(instrReg[opcodeLsb +: opcodeWidth]);
    assign rdIdx     = instrReg[rdLsb +: regIdxWidth];
    assign raIdx     = instrReg[raLsb +: regIdxWidth];
    assign rbIdx     = instrReg[rbLsb +: regIdxWidth];
    assign immediate = {{(wordWidth-immWidth){instrReg[immLsb+immWidth-1]}},
                        instrReg[immLsb +: immWidth]};

    always_comb begin
        aluOp         = aluAdd;
        useImm        = 1'b0;
        wbSel         = wbAlu;
        known         = 1'b1;
        writesReg     = 1'b0;
        checkOverflow = 1'b0;
        case (opcode)
            opAdd:     {writesReg, checkOverflow} = 2'b11;
            opSub:     {aluOp, writesReg, checkOverflow} = {aluSub, 2'b11};
            opAnd:     {aluOp, writesReg} = {aluAnd, 1'b1};
            opOr:      {aluOp, writesReg} = {aluOr, 1'b1};
            opXor:     {aluOp, writesReg} = {aluXor, 1'b1};
            opShl:     {aluOp, writesReg} = {aluShl, 1'b1};
            opShr:     {aluOp, writesReg} = {aluShr, 1'b1};
            opAddi:    {useImm, writesReg, checkOverflow} = 3'b111;
            opLdw:     {wbSel, writesReg} = {wbLoad, 1'b1};
            opRdcause: {wbSel, writesReg} = {wbCause, 1'b1};
            opStw, opBz, opBrk, opEret: ;
            default:   known = 1'b0;
        endcase
    end

    assign isMem        = (opcode == opLdw) || (opcode == opStw);
    assign branchTaken  = (opcode == opBz) && (raValue == '0);
    assign branchTarget = pc + instrBytes + (immediate << 2);

    // an interrupt is only sampled here, before the fetch is issued
    assign fetchBoundary = (state == stFetch) && !busBusy;
    assign busStart      = (fetchBoundary && !trapTaken) || (state == stMemory && !busBusy);
    assign busKind       = !busStart          ? busIdle  :
                           (state == stFetch) ? busFetch :
                           (opcode == opStw)  ? busStore : busLoad;
    assign busAddress    = (state == stFetch) ? pc : raValue + immediate;
    assign busWriteData  = rdValue;   // store data from the rd port

    assign unknownTrap  = (state == stDecode) && !known;
    assign breakTrap    = (state == stDecode) && (opcode == opBrk);
    assign overflowTrap = (state == stExecute) && checkOverflow && aluOverflow;
    assign eret         = (state == stWriteback) && (opcode == opEret);
    assign regWrite     = (state == stWriteback) && writesReg;
    assign regWriteData = (wbSel == wbLoad) ? busReadData : aluResult;

    always_ff @(posedge clk) begin
        if (state == stFetch && busDone) begin
            instrReg <= instruction;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= stFetch;
            pc      <= resetAddress;
            busBusy <= 1'b0;
        end else begin
            if (busStart) begin
                busBusy <= 1'b1;
            end else if (busDone) begin
                busBusy <= 1'b0;
            end
            case (state)
                stFetch: begin
                    if (trapTaken) begin
                        state <= stTrap;     // interrupt at the boundary
                    end else if (busDone) begin
                        state <= stDecode;
                    end
                end
                stDecode:  state <= trapTaken ? stTrap : stExecute;
                stExecute: begin
                    if (trapTaken) begin
                        state <= stTrap;
                    end else begin
                        state <= isMem ? stMemory : stWriteback;
                    end
                end
                stMemory: begin
                    if (busDone) begin
                        state <= stWriteback;
                    end
                end
                stWriteback: begin
                    if (eret) begin
                        pc <= epc;
                    end else begin
                        pc <= branchTaken ? branchTarget : pc + instrBytes;
                    end
                    state <= stFetch;
                end
                stTrap: begin
                    pc    <= isrAddress;
                    state <= stFetch;
                end
                default: state <= stFetch;
            endcase
        end
    end

endmodule

//--- design/cpu32.sv
`timescale 1ns/1ps

module cpu32 import cpuArchPkg::*, cpuCtrlPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   waitRequest,
    input  logic                   readValid,
    input  logic                   interruptRequest,
    input  logic [vectorWidth-1:0] interruptIn,
    input  wordT                   dataIn,
    output logic                   interruptAcknowledge,
    output logic                   read,
    output logic                   write,
    output logic [vectorWidth-1:0] interruptOut,
    output logic [3:0]             bwe,
    output wordT                   dataOut,
    output wordT                   address
);

    // controller to bus unit
    logic    busStart;
    logic    busDone;
    busKindT busKind;
    wordT    busAddress;
    wordT    busWriteData;
    wordT    busReadData;

    // datapath
    wordT    pc;
    wordT    regWriteData;
    wordT    writeData;
    wbSelT   wbSel;
    regIdxT  rdIdx;
    regIdxT  raIdx;
    regIdxT  rbIdx;
    wordT    raValue;
    wordT    rbValue;
    wordT    rdValue;
    logic    regWrite;
    aluOpT   aluOp;
    wordT    aluResult;
    logic    aluOverflow;
    logic    useImm;
    wordT    immediate;
    wordT    operandB;

    // exceptions
    logic    fetchBoundary;
    logic    overflowTrap;
    logic    breakTrap;
    logic    unknownTrap;
    logic    eret;
    logic    trapTaken;
    causeT   cause;
    wordT    epc;

    assign operandB  = useImm ? immediate : rbValue;
    assign writeData = (wbSel == wbCause) ? wordT'(cause) : regWriteData;  // RDCAUSE

    cpuController cpuController (
        .clk, .rstN,
        .instruction (busReadData),
        .busDone, .trapTaken, .busReadData, .aluResult, .rdValue, .raValue, .epc,
        .aluOverflow, .busStart, .regWrite, .fetchBoundary,
        .overflowTrap, .breakTrap, .unknownTrap, .eret,
        .busKind, .busAddress, .busWriteData, .pc, .regWriteData,
        .aluOp, .wbSel, .rdIdx, .raIdx, .rbIdx, .useImm, .immediate
    );

    registerFile registerFile (
        .clk, .rstN, .raIdx, .rbIdx, .rdIdx, .regWrite,
        .regWriteData (writeData),
        .raValue, .rbValue, .rdValue
    );

    executeUnit executeUnit (
        .aluOp,
        .operandA (raValue),
        .operandB, .aluResult, .aluOverflow
    );

    exceptionUnit exceptionUnit (
        .clk, .rstN, .pc, .overflowTrap, .breakTrap, .unknownTrap, .eret,
        .fetchBoundary, .interruptRequest, .interruptIn,
        .trapTaken, .interruptAcknowledge, .interruptOut, .cause, .epc
    );

    busUnit busUnit (
        .clk, .rstN, .busStart, .busKind, .busAddress, .busWriteData,
        .waitRequest, .readValid, .dataIn,
        .read, .write, .bwe, .address, .dataOut, .busDone, .busReadData
    );

endmodule

//--- dv/busMemoryModel.sv
`timescale 1ns/1ps

module busMemoryModel import cpuArchPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       read,
    input  logic       write,
    input  logic [3:0] bwe,
    input  wordT       address,
    input  wordT       dataOut,
    output logic       waitRequest,
    output logic       readValid,
    output wordT       dataIn
);

    localparam int memWords = 1024;   // 4 KB with the halt word at the top

    wordT mem [memWords];
    int   waitStates  = 0;    // set by the testbench between runs
    int   readLatency = 1;    // at least 1
    int   waitLeft;
    int   latLeft;
    wordT readWord;
    logic rstS;
    logic reqS;
    logic acceptS;
    logic writeS;
    logic [3:0] bweS;
    wordT addrS;
    wordT dataS;

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = {6'h3F, 26'(i * 4)};
        end
        waitRequest = 1'b0;
        readValid   = 1'b0;
        dataIn      = '0;
        waitLeft    = 0;
        latLeft     = 0;
        readWord    = '0;
    end

    // sample mid-cycle where the bus is stable
    always @(negedge clk) begin
        rstS    = rstN;
        reqS    = read || write;
        acceptS = (read || write) && !waitRequest;
        writeS  = write;
        bweS    = bwe;
        addrS   = address;
        dataS   = dataOut;
    end

    always @(posedge clk) begin
        #1;
        readValid = 1'b0;
        if (!rstS) begin
            waitLeft = waitStates;
            latLeft  = 0;
        end else begin
            if (latLeft > 0) begin
                latLeft--;
                if (latLeft == 0) begin
                    readValid = 1'b1;
                    dataIn    = readWord;
                end
            end
            if (acceptS) begin
                if (writeS) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (bweS[lane]) begin
                            mem[addrS[11:2]][8*lane +: 8] = dataS[8*lane +: 8];
                        end
                    end
                end else begin
                    readWord = mem[addrS[11:2]];
                    latLeft  = readLatency - 1;
                    if (latLeft == 0) begin
                        readValid = 1'b1;
                        dataIn    = readWord;
                    end
                end
                waitLeft = waitStates;   // reload for the next request
            end else if (reqS && waitLeft > 0) begin
                waitLeft--;
            end
        end
        waitRequest = (waitLeft != 0);
    end

endmodule

//--- dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpuArchPkg::*; ();

    localparam wordT haltAddress = 32'h0000_0FFC;
    localparam wordT eretAddress = 32'h0000_010C;   // last handler word
    // instructions executed per test including handlers
    localparam int aluInstrs    = 21;
    localparam int memInstrs    = 51;
    localparam int branchInstrs = 8;
    localparam int trapInstrs   = 22;
    localparam int irqInstrs    = 18;
    localparam int cycleLimit   =
        200 * (aluInstrs + memInstrs + branchInstrs + trapInstrs + irqInstrs);

    logic       clk;
    logic       rstN;
    logic       interruptRequest;
    logic [3:0] interruptIn;
    logic       interruptAcknowledge;
    logic [3:0] interruptOut;
    logic       read;
    logic       write;
    logic [3:0] bwe;
    logic       waitRequest;
    logic       readValid;
    wordT       dataIn;
    wordT       dataOut;
    wordT       address;

    int          errorCount;
    int          cycleCount;
    int          ackCount;
    int unsigned seed;
    logic        haltSeen;
    logic        firstReadSeen;
    logic        eretFetched;
    logic [3:0]  expectVector;
    wordT        asmPc;

    cpu32 UUT (
        .clk, .rstN, .waitRequest, .readValid, .interruptRequest, .interruptIn, .dataIn,
        .interruptAcknowledge, .read, .write, .interruptOut, .bwe, .dataOut, .address
    );

    busMemoryModel memModel (
        .clk, .rstN, .read, .write, .bwe, .address, .dataOut,
        .waitRequest, .readValid, .dataIn
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: no halt store after %0d cycles", cycleCount);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic wordT nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic checkWord(input string name, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic checkCause(input string name, input causeT actual, input causeT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
        end
    endtask

    // bus and interrupt monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rstN) begin
            if (read && !firstReadSeen) begin
                firstReadSeen = 1'b1;
                checkWord("address", address, resetAddress);
            end
            if (write) begin
                checkWord("bwe", wordT'(bwe), 32'hF);
            end
            if (write && !waitRequest && address == haltAddress) begin
                haltSeen = 1'b1;
            end
            if (read && address == eretAddress && ackCount == 1) begin
                eretFetched = 1'b1;
                checkWord("interruptOut", wordT'(interruptOut), wordT'(expectVector));
            end
            if (interruptAcknowledge) begin
                checkWord("interruptOut", wordT'(interruptOut), wordT'(expectVector));
                if (ackCount == 1) begin
                    checkBit("eretFetched", eretFetched, 1'b1);
                end
                ackCount++;
            end
        end
    end

    function automatic wordT encR(input opcodeT op, input int rd, input int ra, input int rb);
        return {op, 5'(rd), 5'(ra), 5'(rb), 11'h0};
    endfunction

    function automatic wordT encI(input opcodeT op, input int rd, input int ra,
                                  input logic [15:0] imm);
        return {op, 5'(rd), 5'(ra), imm};
    endfunction

    function automatic wordT readMem(input wordT addr);
        return memModel.mem[addr[11:2]];
    endfunction

    task automatic writeMem(input wordT addr, input wordT value);
        memModel.mem[addr[11:2]] = value;
    endtask

    task automatic emit(input wordT instr);
        writeMem(asmPc, instr);
        asmPc += 4;
    endtask

    task automatic clearMemory();
        for (int i = 0; i < 1024; i++) begin
            memModel.mem[i] = {6'h3F, 26'(i * 4)};   // unknown opcode tagged by address
        end
        asmPc = resetAddress;
    endtask

    task automatic installHandler();
        asmPc = isrAddress;
        emit(encR(opRdcause, 20, 0, 0));
        emit(encI(opStw, 20, 21, 16'h0));    // cause log at r21
        emit(encI(opAddi, 21, 21, 16'h4));
        emit(encR(opEret, 0, 0, 0));
    endtask

    task automatic resetDut();
        @(posedge clk);
        #1;
        rstN          = 1'b0;
        haltSeen      = 1'b0;
        firstReadSeen = 1'b0;
        eretFetched   = 1'b0;
        ackCount      = 0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        checkBit("read", read, 1'b0);
        checkBit("write", write, 1'b0);
        checkBit("interruptAcknowledge", interruptAcknowledge, 1'b0);
        @(posedge clk);
        #1 rstN = 1'b1;
    endtask

    task automatic runProgram();
        resetDut();
        wait (haltSeen);
        repeat (4) @(posedge clk);
        checkBit("firstReadSeen", firstReadSeen, 1'b1);
    endtask

    task automatic testAlu();
        wordT        a;
        wordT        b;
        logic [15:0] imm;
        a   = nextRand();
        b   = nextRand();
        imm = nextRand() >> 8;
        a[30] = a[31];     // keep add and sub clear of overflow
        b[30] = b[31];
        clearMemory();
        writeMem(32'h800, a);
        writeMem(32'h804, b);
        emit(encI(opLdw, 1, 0, 16'h800));
        emit(encI(opLdw, 2, 0, 16'h804));
        emit(encR(opAdd, 3, 1, 2));
        emit(encR(opSub, 4, 1, 2));
        emit(encR(opAnd, 5, 1, 2));
        emit(encR(opOr, 6, 1, 2));
        emit(encR(opXor, 7, 1, 2));
        emit(encR(opShl, 8, 1, 2));
        emit(encR(opShr, 9, 1, 2));
        emit(encI(opAddi, 10, 1, imm));
        emit(encR(opAdd, 0, 1, 2));      // write aimed at r0
        for (int r = 3; r <= 10; r++) begin
            emit(encI(opStw, r, 0, 16'(32'h900 + (r - 3) * 4)));
        end
        emit(encI(opStw, 0, 0, 16'h920));
        emit(encI(opStw, 0, 0, haltAddress[15:0]));
        runProgram();
        checkWord("add", readMem(32'h900), a + b);
        checkWord("sub", readMem(32'h904), a - b);
        checkWord("and", readMem(32'h908), a & b);
        checkWord("or", readMem(32'h90C), a | b);
        checkWord("xor", readMem(32'h910), a ^ b);
        checkWord("shl", readMem(32'h914), a << b[4:0]);
        checkWord("shr", readMem(32'h918), a >> b[4:0]);
        checkWord("addi", readMem(32'h91C), a + {{16{imm[15]}}, imm});
        checkWord("r0", readMem(32'h920), 32'h0);
    endtask

    task automatic testLoadStore();
        wordT values [4];
        for (int run = 0; run < 3; run++) begin
            clearMemory();
            memModel.waitStates  = nextRand() % 4;
            memModel.readLatency = 1 + nextRand() % 4;
            for (int k = 0; k < 4; k++) begin
                values[k] = nextRand();
                writeMem(32'h800 + k * 4, values[k]);
                emit(encI(opLdw, k + 1, 0, 16'(32'h800 + k * 4)));
                emit(encI(opStw, k + 1, 0, 16'(32'h900 + k * 4)));
                emit(encI(opLdw, k + 5, 0, 16'(32'h900 + k * 4)));
                emit(encI(opStw, k + 5, 0, 16'(32'h940 + k * 4)));
            end
            emit(encI(opStw, 0, 0, haltAddress[15:0]));
            runProgram();
            for (int k = 0; k < 4; k++) begin
                checkWord("store", readMem(32'h900 + k * 4), values[k]);
                checkWord("round trip", readMem(32'h940 + k * 4), values[k]);
            end
        end
        memModel.waitStates  = 0;
        memModel.readLatency = 1;
    endtask

    task automatic testBranch();
        clearMemory();
        emit(encI(opAddi, 2, 0, 16'h5));
        emit(encI(opAddi, 3, 0, 16'h11));   // marker
        emit(encI(opBz, 0, 0, 16'h1));      // taken and skips one word
        emit(encI(opStw, 3, 0, 16'h900));
        emit(encI(opStw, 3, 0, 16'h904));
        emit(encI(opBz, 0, 2, 16'h1));      // r2 nonzero so it falls through
        emit(encI(opStw, 3, 0, 16'h908));
        emit(encI(opStw, 3, 0, 16'h90C));
        emit(encI(opStw, 0, 0, haltAddress[15:0]));
        runProgram();
        checkWord("skipped store", readMem(32'h900), {6'h3F, 26'h900});
        checkWord("branch target", readMem(32'h904), 32'h11);
        checkWord("fall through", readMem(32'h908), 32'h11);
        checkWord("after branch", readMem(32'h90C), 32'h11);
    endtask

    task automatic testTraps();
        clearMemory();
        installHandler();
        asmPc = resetAddress;
        writeMem(32'h800, 32'h7FFF_FFFF);
        writeMem(32'h804, 32'h1);
        emit(encI(opAddi, 21, 0, 16'h980));
        emit(encR(opBrk, 0, 0, 0));
        emit(encI(opAddi, 5, 0, 16'h22));    // resumes here after BRK
        emit(encI(opStw, 5, 0, 16'h900));
        emit({6'h3F, 26'h0});
        emit(encI(opLdw, 1, 0, 16'h800));
        emit(encI(opLdw, 2, 0, 16'h804));
        emit(encR(opAdd, 3, 1, 2));          // signed overflow leaves r3 untouched
        emit(encI(opStw, 3, 0, 16'h904));
        emit(encI(opStw, 0, 0, haltAddress[15:0]));
        runProgram();
        checkCause("break cause", causeT'(readMem(32'h980)), 5'd2);
        checkCause("unknown cause", causeT'(readMem(32'h984)), 5'd4);
        checkCause("overflow cause", causeT'(readMem(32'h988)), 5'd1);
        checkWord("cause word", readMem(32'h988), 32'h1);
        checkWord("resume marker", readMem(32'h900), 32'h22);
        checkWord("overflow result", readMem(32'h904), 32'h0);
    endtask

    task automatic driveInterrupts(input logic [3:0] v1, input logic [3:0] v2);
        do @(negedge clk); while (!(read && address == 32'h8));
        @(posedge clk);
        #1;
        expectVector     = v1;
        interruptIn      = v1;
        interruptRequest = 1'b1;
        do @(negedge clk); while (!interruptAcknowledge);
        @(posedge clk);
        #1;
        interruptIn = v2;    // held high through the handler
        do @(negedge clk); while (!eretFetched);
        @(posedge clk);
        #1;
        expectVector = v2;
        do @(negedge clk); while (ackCount < 2);
        @(posedge clk);
        #1;
        interruptRequest = 1'b0;
    endtask

    task automatic testInterrupt();
        logic [3:0] v1;
        logic [3:0] v2;
        v1 = nextRand() >> 12;
        v2 = v1 ^ 4'h5;
        clearMemory();
        installHandler();
        asmPc = resetAddress;
        emit(encI(opAddi, 21, 0, 16'h980));
        emit(encI(opAddi, 7, 0, 16'h0));
        for (int i = 0; i < 6; i++) begin
            emit(encI(opAddi, 7, 7, 16'h1));
        end
        emit(encI(opStw, 7, 0, 16'h900));
        emit(encI(opStw, 0, 0, haltAddress[15:0]));
        fork
            runProgram();
            driveInterrupts(v1, v2);
        join
        checkWord("ackCount", ackCount, 32'd2);
        checkCause("first irq cause", causeT'(readMem(32'h980)), 5'd16 + v1);
        checkCause("second irq cause", causeT'(readMem(32'h984)), 5'd16 + v2);
        checkWord("count marker", readMem(32'h900), 32'd6);
    endtask

    initial begin
        rstN             = 1'b0;
        interruptRequest = 1'b0;
        interruptIn      = '0;
        expectVector     = '0;
        errorCount       = 0;
        cycleCount       = 0;
        ackCount         = 0;
        haltSeen         = 1'b0;
        firstReadSeen    = 1'b0;
        eretFetched      = 1'b0;
        seed             = 18754;
        testAlu();
        testLoadStore();
        testBranch();
        testTraps();
        testInterrupt();
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/cpuArchPkg.sv
design/cpuCtrlPkg.sv
design/executeUnit.sv
design/registerFile.sv
design/exceptionUnit.sv
design/busUnit.sv
design/cpuController.sv
design/cpu32.sv
dv/busMemoryModel.sv
dv/cpuTb.sv
